// File: files.f
common/mips_pkg.sv
hw/fetch/instr_mem.sv
hw/fetch/fetch_unit.sv
hw/decode/control_unit.sv
hw/decode/bank_registers.sv
hw/execute/execute_unit.sv
hw/mips_core.sv
tests/tb_mips_core.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_mips_core
FILELIST := files.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_mips_core.sv
// self-checking testbench for mips_core, loads random programs over wishbone and checks writebacks
`timescale 1ns/1ps

module tb_mips_core;

	localparam int ADDR_WIDTH   = 7;
	localparam int DEPTH        = 2 ** ADDR_WIDTH;
	localparam int PROG_LEN     = 48;
	localparam int N_PROGS      = 6;
	localparam int TOTAL_INSTR  = PROG_LEN * N_PROGS;
	localparam int RESET_CYCLES = 10;
	localparam int DRAIN_CYCLES = 8;
	localparam int ACK_LIMIT    = 16;
	// a wishbone access takes three cycles, four are budgeted
	localparam int LOAD_CYCLES  = (2 * DEPTH + TOTAL_INSTR) * 4 + RESET_CYCLES
		+ N_PROGS * DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = TOTAL_INSTR * 4 + LOAD_CYCLES + 200;

	// program kinds
	localparam int K_ITYPE   = 0;
	localparam int K_INDEP   = 1;
	localparam int K_CHAIN   = 2;
	localparam int K_ILLEGAL = 3;

	logic                         clock_i;
	logic                         rst_i;
	logic                         wb_cyc_i;
	logic                         wb_stb_i;
	logic                         wb_we_i;
	logic [ADDR_WIDTH-1:0]        wb_adr_i;
	logic [mips_pkg::NB_DATA-1:0] wb_dat_i;
	logic [mips_pkg::NB_DATA-1:0] wb_dat_o;
	logic                         wb_ack_o;
	logic                         run_i;
	logic                         wb_valid_o;
	logic [mips_pkg::NB_REG-1:0]  wb_reg_o;
	logic [mips_pkg::NB_DATA-1:0] wb_data_o;

	logic [31:0]                  seed;
	int                           pc_model;
	logic [mips_pkg::NB_DATA-1:0] model_regs [mips_pkg::N_REGS];
	logic [mips_pkg::NB_REG-1:0]  exp_reg [$];
	logic [mips_pkg::NB_DATA-1:0] exp_data [$];
	logic [31:0]                  prog [$];
	logic [31:0]                  pattern [$];

	mips_core #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) uut (
		.clock_i   (clock_i),
		.rst_i     (rst_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack_o  (wb_ack_o),
		.run_i     (run_i),
		.wb_valid_o(wb_valid_o),
		.wb_reg_o  (wb_reg_o),
		.wb_data_o (wb_data_o)
	);

	initial begin
		clock_i = 1'b0;
		forever #4 clock_i = ~clock_i;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// upper bits of the lcg are the better ones
	function automatic int unsigned rand_range(input int unsigned n);
		return (lcg_next() >> 16) % n;
	endfunction

	function automatic logic [4:0] rand_reg();
		return 5'(1 + rand_range(31));
	endfunction

	function automatic logic [31:0] rand_rtype(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd);
		logic [5:0] fn;
		case (rand_range(6))
			0: fn = mips_pkg::FN_ADD;
			1: fn = mips_pkg::FN_SUB;
			2: fn = mips_pkg::FN_AND;
			3: fn = mips_pkg::FN_OR;
			4: fn = mips_pkg::FN_XOR;
			default: fn = mips_pkg::FN_SLT;
		endcase
		return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	// immediate is fully random, so half of them are negative
	function automatic logic [31:0] rand_itype(input logic [4:0] rs, input logic [4:0] rt);
		logic [5:0] op;
		case (rand_range(6))
			0: op = mips_pkg::OP_ADDI;
			1: op = mips_pkg::OP_SLTI;
			2: op = mips_pkg::OP_ANDI;
			3: op = mips_pkg::OP_ORI;
			4: op = mips_pkg::OP_XORI;
			default: op = mips_pkg::OP_LUI;
		endcase
		return {op, rs, rt, 16'(lcg_next())};
	endfunction

	// reference model, one instruction in program order
	task automatic model_step(input logic [31:0] w);
		logic [5:0]  op;
		logic [4:0]  dest;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] res;
		logic        known;
		op    = w[31:26];
		a     = model_regs[w[25:21]];
		b     = model_regs[w[20:16]];
		sext  = {{16{w[15]}}, w[15:0]};
		dest  = w[20:16];
		known = 1'b1;
		res   = '0;
		case (op)
			mips_pkg::OP_RTYPE: begin
				dest = w[15:11];
				case (w[5:0])
					mips_pkg::FN_ADD: res = a + b;
					mips_pkg::FN_SUB: res = a - b;
					mips_pkg::FN_AND: res = a & b;
					mips_pkg::FN_OR:  res = a | b;
					mips_pkg::FN_XOR: res = a ^ b;
					mips_pkg::FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
					default:          known = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI: res = a + sext;
			mips_pkg::OP_SLTI: res = {31'd0, $signed(a) < $signed(sext)};
			mips_pkg::OP_ANDI: res = a & {16'd0, w[15:0]};
			mips_pkg::OP_ORI:  res = a | {16'd0, w[15:0]};
			mips_pkg::OP_XORI: res = a ^ {16'd0, w[15:0]};
			mips_pkg::OP_LUI:  res = {w[15:0], 16'd0};
			default:           known = 1'b0;
		endcase
		if (known && dest != 5'd0) begin
			model_regs[dest] = res;
			exp_reg.push_back(dest);
			exp_data.push_back(res);
		end
	endtask

	task automatic gen_program(input int kind);
		logic [4:0]  hist [$];
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [31:0] w;
		// most recent destination first, distances 1 to 3
		hist.push_back(5'd1);
		hist.push_back(5'd2);
		hist.push_back(5'd3);
		prog.delete();
		for (int i = 0; i < PROG_LEN; i++) begin
			rs = rand_reg();
			rt = rand_reg();
			rd = rand_reg();
			case (kind)
				K_ITYPE: w = rand_itype(rs, rd);
				K_INDEP: begin
					// sources below r16, destinations from r16 up
					w = rand_rtype(5'(1 + rand_range(15)), 5'(1 + rand_range(15)),
						5'(16 + rand_range(16)));
				end
				K_CHAIN: begin
					rs = hist[rand_range(3)];
					rt = hist[rand_range(3)];
					w = (rand_range(2) != 0) ? rand_rtype(rs, rt, rd) : rand_itype(rs, rd);
				end
				default: begin
					case (rand_range(5))
						0: w = {((rand_range(2) != 0) ? 6'h23 : 6'h04), 26'(lcg_next())};
						1: w = {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, 6'h27};
						2: w = (rand_range(2) != 0) ? rand_rtype(rs, rt, 5'd0) : rand_itype(rs, 5'd0);
						3: w = rand_rtype(5'd0, (rand_range(2) != 0) ? 5'd0 : rt, rd);
						default: w = rand_rtype(rs, rt, rd);
					endcase
				end
			endcase
			hist.push_front(rd);
			hist.delete(3);
			model_step(w);
			prog.push_back(w);
		end
	endtask

	task automatic check_word(input logic [mips_pkg::NB_DATA-1:0] got,
		input logic [mips_pkg::NB_DATA-1:0] want, input logic [ADDR_WIDTH-1:0] adr);
		if (got !== want) begin
			abort_run($sformatf("error at time %0t: read of address %0d gave %h, expected %h",
				$time, adr, got, want));
		end
	endtask

	task automatic check_wb(input logic [mips_pkg::NB_REG-1:0] got_reg,
		input logic [mips_pkg::NB_DATA-1:0] got_data, input logic [mips_pkg::NB_REG-1:0] want_reg,
		input logic [mips_pkg::NB_DATA-1:0] want_data);
		if (got_reg !== want_reg || got_data !== want_data) begin
			abort_run($sformatf("error at time %0t: writeback r%0d = %h, expected r%0d = %h",
				$time, got_reg, got_data, want_reg, want_data));
		end
	endtask

	// one classic cycle, checks a single ack
	task automatic wb_access(input logic we, input logic [ADDR_WIDTH-1:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
		int waited;
		@(posedge clock_i);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= wdat;
		waited = 0;
		@(negedge clock_i);
		while (!wb_ack_o) begin
			waited++;
			if (waited > ACK_LIMIT) begin
				abort_run($sformatf("no wishbone ack for address %0d", adr));
			end
			@(negedge clock_i);
		end
		rdat = wb_dat_o;
		@(posedge clock_i);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		@(negedge clock_i);
		if (wb_ack_o) begin
			abort_run($sformatf("wishbone ack for address %0d lasted more than one cycle", adr));
		end
	endtask

	task automatic run_test(input int kind, input bit toggle);
		logic [31:0] unused;
		int          fetched;
		bit          go;
		gen_program(kind);
		for (int i = 0; i < PROG_LEN; i++) begin
			wb_access(1'b1, ADDR_WIDTH'((pc_model + i) % DEPTH), prog[i], unused);
		end
		fetched = 0;
		while (fetched < PROG_LEN) begin
			@(posedge clock_i);
			go = toggle ? (rand_range(2) != 0) : 1'b1;
			run_i <= go;
			if (go) begin
				fetched++;
			end
		end
		@(posedge clock_i);
		run_i <= 1'b0;
		pc_model = (pc_model + PROG_LEN) % DEPTH;
		while (exp_reg.size() != 0) begin
			@(negedge clock_i);
		end
		// late or extra writebacks would show up here
		repeat (DRAIN_CYCLES) @(negedge clock_i);
	endtask

	always @(negedge clock_i) begin
		if (!rst_i && wb_valid_o) begin
			if (exp_reg.size() == 0) begin
				abort_run($sformatf("writeback to r%0d at time %0t that no instruction should make",
					wb_reg_o, $time));
			end else begin
				check_wb(wb_reg_o, wb_data_o, exp_reg.pop_front(), exp_data.pop_front());
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock_i);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] rdat;
		rst_i    = 1'b1;
		run_i    = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		seed     = 32'h8239;
		pc_model = 0;
		for (int r = 0; r < mips_pkg::N_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clock_i);
		rst_i <= 1'b0;

		// write burst over the whole RAM, then read back
		for (int a = 0; a < DEPTH; a++) begin
			pattern.push_back(lcg_next());
			wb_access(1'b1, ADDR_WIDTH'(a), pattern[a], rdat);
		end
		for (int a = 0; a < DEPTH; a++) begin
			wb_access(1'b0, ADDR_WIDTH'(a), '0, rdat);
			check_word(rdat, pattern[a], ADDR_WIDTH'(a));
		end

		// registers carry over between programs, pc wraps through the RAM
		run_test(K_ITYPE, 1'b0);
		run_test(K_INDEP, 1'b0);
		run_test(K_CHAIN, 1'b0);
		run_test(K_CHAIN, 1'b1);
		run_test(K_ILLEGAL, 1'b0);
		run_test(K_ILLEGAL, 1'b1);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: hw/mips_core.sv
// top level of the MIPS subset pipeline: fetch, decode, execute and writeback trace
`timescale 1ns/1ps

module mips_core #(
	parameter int ADDR_WIDTH = 7
) (
	input  logic                         clock_i,
	input  logic                         rst_i,

	// instruction load port, wishbone classic slave
	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	input  logic                         wb_we_i,
	input  logic [ADDR_WIDTH-1:0]        wb_adr_i,
	input  logic [mips_pkg::NB_DATA-1:0] wb_dat_i,
	output logic [mips_pkg::NB_DATA-1:0] wb_dat_o,
	output logic                         wb_ack_o,

	input  logic                         run_i,

	// writeback trace
	output logic                         wb_valid_o,
	output logic [mips_pkg::NB_REG-1:0]  wb_reg_o,
	output logic [mips_pkg::NB_DATA-1:0] wb_data_o
);

	logic [mips_pkg::NB_DATA-1:0] instr;
	logic                         instr_valid;
	mips_pkg::alu_op_t            alu_op;
	logic [mips_pkg::NB_REG-1:0]  rs;
	logic [mips_pkg::NB_REG-1:0]  rt;
	logic [mips_pkg::NB_REG-1:0]  dest;
	logic [mips_pkg::NB_DATA-1:0] imm;
	logic                         use_imm;
	logic                         reg_write;
	logic [mips_pkg::NB_DATA-1:0] data_ra;
	logic [mips_pkg::NB_DATA-1:0] data_rb;

	// pc of the fetched word is not needed without branches
	fetch_unit #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_fetch (
		.clock_i (clock_i),
		.rst_i   (rst_i),
		.run_i   (run_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i (wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.instr_o (instr),
		.pc_o    (),
		.valid_o (instr_valid)
	);

	control_unit u_control (
		.instr_i    (instr),
		.valid_i    (instr_valid),
		.alu_op_o   (alu_op),
		.rs_o       (rs),
		.rt_o       (rt),
		.dest_o     (dest),
		.imm_o      (imm),
		.use_imm_o  (use_imm),
		.reg_write_o(reg_write)
	);

	// writeback trace doubles as the bank write port
	bank_registers u_bank (
		.clock_i  (clock_i),
		.rst_i    (rst_i),
		.addr_ra_i(rs),
		.addr_rb_i(rt),
		.data_ra_o(data_ra),
		.data_rb_o(data_rb),
		.rw_i     (wb_valid_o),
		.addr_rw_i(wb_reg_o),
		.data_rw_i(wb_data_o)
	);

	execute_unit u_execute (
		.clock_i    (clock_i),
		.rst_i      (rst_i),
		.alu_op_i   (alu_op),
		.rs_i       (rs),
		.rt_i       (rt),
		.dest_i     (dest),
		.imm_i      (imm),
		.use_imm_i  (use_imm),
		.reg_write_i(reg_write),
		.data_ra_i  (data_ra),
		.data_rb_i  (data_rb),
		.wb_valid_o (wb_valid_o),
		.wb_reg_o   (wb_reg_o),
		.wb_data_o  (wb_data_o)
	);

endmodule

// File: hw/execute/execute_unit.sv
// decode/execute register, forwarding, ALU and writeback register of the pipeline
`timescale 1ns/1ps

module execute_unit (
	input  logic                         clock_i,
	input  logic                         rst_i,

	// decoded slot
	input  mips_pkg::alu_op_t            alu_op_i,
	input  logic [mips_pkg::NB_REG-1:0]  rs_i,
	input  logic [mips_pkg::NB_REG-1:0]  rt_i,
	input  logic [mips_pkg::NB_REG-1:0]  dest_i,
	input  logic [mips_pkg::NB_DATA-1:0] imm_i,
	input  logic                         use_imm_i,
	input  logic                         reg_write_i,
	input  logic [mips_pkg::NB_DATA-1:0] data_ra_i,
	input  logic [mips_pkg::NB_DATA-1:0] data_rb_i,

	// writeback register, also the trace port
	output logic                         wb_valid_o,
	output logic [mips_pkg::NB_REG-1:0]  wb_reg_o,
	output logic [mips_pkg::NB_DATA-1:0] wb_data_o
);

	mips_pkg::alu_op_t            alu_op_q;
	logic [mips_pkg::NB_REG-1:0]  rs_q;
	logic [mips_pkg::NB_REG-1:0]  rt_q;
	logic [mips_pkg::NB_REG-1:0]  dest_q;
	logic [mips_pkg::NB_DATA-1:0] imm_q;
	logic [mips_pkg::NB_DATA-1:0] ra_q;
	logic [mips_pkg::NB_DATA-1:0] rb_q;
	logic                         use_imm_q;
	logic                         reg_write_q;
	logic [mips_pkg::NB_DATA-1:0] op_a;
	logic [mips_pkg::NB_DATA-1:0] rt_data;
	logic [mips_pkg::NB_DATA-1:0] op_b;
	logic [mips_pkg::NB_DATA-1:0] alu_result;

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			reg_write_q <= 1'b0;
			wb_valid_o  <= 1'b0;
		end else begin
			reg_write_q <= reg_write_i;
			wb_valid_o  <= reg_write_q;
		end
	end

	always_ff @(posedge clock_i) begin
		alu_op_q  <= alu_op_i;
		rs_q      <= rs_i;
		rt_q      <= rt_i;
		dest_q    <= dest_i;
		imm_q     <= imm_i;
		use_imm_q <= use_imm_i;
		ra_q      <= data_ra_i;
		rb_q      <= data_rb_i;
		wb_reg_o  <= dest_q;
		wb_data_o <= alu_result;
	end

	// distance-1 hazard, the bank bypass covers distance 2
	assign op_a = (wb_valid_o && wb_reg_o != '0 && wb_reg_o == rs_q) ? wb_data_o : ra_q;
	assign rt_data = (wb_valid_o && wb_reg_o != '0 && wb_reg_o == rt_q) ? wb_data_o : rb_q;
	assign op_b = use_imm_q ? imm_q : rt_data;

	always_comb begin
		case (alu_op_q)
			mips_pkg::ALU_ADD: alu_result = op_a + op_b;
			mips_pkg::ALU_SUB: alu_result = op_a - op_b;
			mips_pkg::ALU_AND: alu_result = op_a & op_b;
			mips_pkg::ALU_OR:  alu_result = op_a | op_b;
			mips_pkg::ALU_XOR: alu_result = op_a ^ op_b;
			mips_pkg::ALU_SLT: begin
				alu_result = {{(mips_pkg::NB_DATA-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			end
			mips_pkg::ALU_LUI: alu_result = op_b << mips_pkg::NB_IMM;
			default:           alu_result = '0;
		endcase
	end

	a_slt_is_bool: assert property (@(posedge clock_i) disable iff (rst_i)
		(reg_write_q && alu_op_q == mips_pkg::ALU_SLT) |=>
		(wb_data_o[mips_pkg::NB_DATA-1:1] == '0));

endmodule

// File: hw/decode/bank_registers.sv
// 32-entry register file with two read ports, one write port and write-through bypass
`timescale 1ns/1ps

module bank_registers (
	input  logic                         clock_i,
	input  logic                         rst_i,

	// read ports, combinational
	input  logic [mips_pkg::NB_REG-1:0]  addr_ra_i,
	input  logic [mips_pkg::NB_REG-1:0]  addr_rb_i,
	output logic [mips_pkg::NB_DATA-1:0] data_ra_o,
	output logic [mips_pkg::NB_DATA-1:0] data_rb_o,

	// write port from writeback
	input  logic                         rw_i,
	input  logic [mips_pkg::NB_REG-1:0]  addr_rw_i,
	input  logic [mips_pkg::NB_DATA-1:0] data_rw_i
);

	logic [mips_pkg::NB_DATA-1:0] regs [mips_pkg::N_REGS];

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			for (int i = 0; i < mips_pkg::N_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rw_i && addr_rw_i != '0) begin
			regs[addr_rw_i] <= data_rw_i;
		end
	end

	// r0 is hardwired to zero
	// same-cycle write wins over the stored value
	assign data_ra_o = (addr_ra_i == '0) ? '0 :
		(rw_i && addr_rw_i == addr_ra_i) ? data_rw_i : regs[addr_ra_i];

	assign data_rb_o = (addr_rb_i == '0) ? '0 :
		(rw_i && addr_rw_i == addr_rb_i) ? data_rw_i : regs[addr_rb_i];

	// decode filters r0 before the write reaches the bank
	a_no_r0_write: assert property (@(posedge clock_i) disable iff (rst_i)
		!(rw_i && addr_rw_i == '0));

endmodule

// File: hw/decode/control_unit.sv
// combinational decoder turning a fetched word into ALU op, register fields and immediate
`timescale 1ns/1ps

module control_unit (
	input  logic [mips_pkg::NB_DATA-1:0] instr_i,
	input  logic                         valid_i,
	output mips_pkg::alu_op_t            alu_op_o,
	output logic [mips_pkg::NB_REG-1:0]  rs_o,
	output logic [mips_pkg::NB_REG-1:0]  rt_o,
	output logic [mips_pkg::NB_REG-1:0]  dest_o,
	output logic [mips_pkg::NB_DATA-1:0] imm_o,
	output logic                         use_imm_o,
	output logic                         reg_write_o
);

	logic [mips_pkg::NB_OP-1:0]  opcode;
	logic [mips_pkg::NB_OP-1:0]  funct;
	logic [mips_pkg::NB_REG-1:0] rd;
	logic [mips_pkg::NB_IMM-1:0] imm;
	logic                        known;
	logic                        sign_ext;

	// standard MIPS field layout
	assign opcode = instr_i[31:26];
	assign rs_o   = instr_i[25:21];
	assign rt_o   = instr_i[20:16];
	assign rd     = instr_i[15:11];
	assign funct  = instr_i[5:0];
	assign imm    = instr_i[15:0];

	always_comb begin
		alu_op_o  = mips_pkg::ALU_ADD;
		use_imm_o = 1'b1;
		sign_ext  = 1'b0;
		known     = 1'b1;
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				use_imm_o = 1'b0;
				case (funct)
					mips_pkg::FN_ADD: alu_op_o = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_op_o = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op_o = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_op_o = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: alu_op_o = mips_pkg::ALU_XOR;
					mips_pkg::FN_SLT: alu_op_o = mips_pkg::ALU_SLT;
					default:          known    = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI: begin
				alu_op_o = mips_pkg::ALU_ADD;
				sign_ext = 1'b1;
			end
			mips_pkg::OP_SLTI: begin
				alu_op_o = mips_pkg::ALU_SLT;
				sign_ext = 1'b1;
			end
			mips_pkg::OP_ANDI: alu_op_o = mips_pkg::ALU_AND;
			mips_pkg::OP_ORI:  alu_op_o = mips_pkg::ALU_OR;
			mips_pkg::OP_XORI: alu_op_o = mips_pkg::ALU_XOR;
			mips_pkg::OP_LUI:  alu_op_o = mips_pkg::ALU_LUI;
			default:           known    = 1'b0;
		endcase
	end

	// rd for R-type, rt for I-type
	assign dest_o = use_imm_o ? rt_o : rd;

	// lui takes the raw immediate, the ALU shifts it
	assign imm_o = sign_ext ?
		{{(mips_pkg::NB_DATA - mips_pkg::NB_IMM){imm[mips_pkg::NB_IMM-1]}}, imm} :
		{{(mips_pkg::NB_DATA - mips_pkg::NB_IMM){1'b0}}, imm};

	// r0 writes are dropped here so nothing downstream sees them
	assign reg_write_o = valid_i && known && (dest_o != '0);

endmodule

// File: hw/fetch/fetch_unit.sv
// program counter and run control in front of the instruction RAM, feeding decode
`timescale 1ns/1ps

module fetch_unit #(
	parameter int ADDR_WIDTH = 7
) (
	input  logic                         clock_i,
	input  logic                         rst_i,
	input  logic                         run_i,

	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	input  logic                         wb_we_i,
	input  logic [ADDR_WIDTH-1:0]        wb_adr_i,
	input  logic [mips_pkg::NB_DATA-1:0] wb_dat_i,
	output logic [mips_pkg::NB_DATA-1:0] wb_dat_o,
	output logic                         wb_ack_o,

	output logic [mips_pkg::NB_DATA-1:0] instr_o,
	output logic [ADDR_WIDTH-1:0]        pc_o,
	output logic                         valid_o
);

	logic [ADDR_WIDTH-1:0] pc_q;

	instr_mem #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_instr_mem (
		.clock_i  (clock_i),
		.rst_i    (rst_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.rd_addr_i(pc_q),
		.rd_data_o(instr_o)
	);

	// pc wraps at memory depth, holds while stopped
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			pc_q    <= '0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= run_i;
			if (run_i) begin
				pc_q <= pc_q + 1'b1;
			end
		end
	end

	// pc follows the word out of the RAM
	always_ff @(posedge clock_i) begin
		if (run_i) begin
			pc_o <= pc_q;
		end
	end

	// loading is only legal with the core stopped
	a_no_wb_while_run: assert property (@(posedge clock_i) disable iff (rst_i)
		!(wb_cyc_i && wb_stb_i && run_i));

endmodule

// File: hw/fetch/instr_mem.sv
// instruction RAM, loaded over a Wishbone classic slave port and read by fetch each cycle
`timescale 1ns/1ps

module instr_mem #(
	parameter int ADDR_WIDTH = 7
) (
	input  logic                         clock_i,
	input  logic                         rst_i,

	// wishbone classic slave
	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	input  logic                         wb_we_i,
	input  logic [ADDR_WIDTH-1:0]        wb_adr_i,
	input  logic [mips_pkg::NB_DATA-1:0] wb_dat_i,
	output logic [mips_pkg::NB_DATA-1:0] wb_dat_o,
	output logic                         wb_ack_o,

	// fetch read port, one cycle latency
	input  logic [ADDR_WIDTH-1:0]        rd_addr_i,
	output logic [mips_pkg::NB_DATA-1:0] rd_data_o
);

	localparam int DEPTH = 2 ** ADDR_WIDTH;

	logic [mips_pkg::NB_DATA-1:0] mem [DEPTH];
	logic                         wb_req;

	// new request only while ack is low, so each cycle gets a single ack
	assign wb_req = wb_cyc_i && wb_stb_i && !wb_ack_o;

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= wb_req;
		end
	end

	// write lands on the same edge that raises ack
	always_ff @(posedge clock_i) begin
		if (wb_req && wb_we_i) begin
			mem[wb_adr_i] <= wb_dat_i;
		end
		if (wb_req) begin
			wb_dat_o <= mem[wb_adr_i];
		end
	end

	// fetch side reads every cycle
	always_ff @(posedge clock_i) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

// File: common/mips_pkg.sv
// shared widths, instruction encodings and ALU operation codes, referenced by scoped names
package mips_pkg;

	// datapath widths
	localparam int NB_DATA = 32;
	localparam int NB_REG  = 5;
	localparam int NB_OP   = 6;

	// immediate field width of I-type words
	localparam int NB_IMM  = 16;

	// register bank depth
	localparam int N_REGS  = 32;

	// opcodes, standard MIPS values
	localparam logic [NB_OP-1:0] OP_RTYPE = 6'h00;
	localparam logic [NB_OP-1:0] OP_ADDI  = 6'h08;
	localparam logic [NB_OP-1:0] OP_SLTI  = 6'h0A;
	localparam logic [NB_OP-1:0] OP_ANDI  = 6'h0C;
	localparam logic [NB_OP-1:0] OP_ORI   = 6'h0D;
	localparam logic [NB_OP-1:0] OP_XORI  = 6'h0E;
	localparam logic [NB_OP-1:0] OP_LUI   = 6'h0F;

	// function field for R-type words
	localparam logic [NB_OP-1:0] FN_ADD = 6'h20;
	localparam logic [NB_OP-1:0] FN_SUB = 6'h22;
	localparam logic [NB_OP-1:0] FN_AND = 6'h24;
	localparam logic [NB_OP-1:0] FN_OR  = 6'h25;
	localparam logic [NB_OP-1:0] FN_XOR = 6'h26;
	localparam logic [NB_OP-1:0] FN_SLT = 6'h2A;

	// operation handed from decode to the ALU
	// lui shifts operand B up by the immediate width
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,
		ALU_LUI = 3'd6
	} alu_op_t;

endpackage
